// ==== Bender.yml ====
package:
  name: busDatapath

sources:
  - source/busCpuPkg.sv
  - source/busArbiter.sv
  - source/fetchRegisters.sv
  - source/registerFile.sv
  - source/aluUnit.sv
  - source/memoryInterface.sv
  - source/busDatapath.sv
  - target: test
    files:
      - dv/busDatapath_chk.sv
      - dv/busDatapathTb.sv

// ==== busDatapath.f ====
source/busCpuPkg.sv
source/busArbiter.sv
source/fetchRegisters.sv
source/registerFile.sv
source/aluUnit.sv
source/memoryInterface.sv
source/busDatapath.sv
dv/busDatapath_chk.sv
dv/busDatapathTb.sv

// ==== dv/busDatapathTb.sv ====
`timescale 1ns/1ps
module busDatapathTb;
    import busCpuPkg::*;

    localparam int clockPeriod = 4;
    localparam int resetCycles = 16;
    localparam int driveDelay  = 1;
    localparam int sampleDelay = 2;
    localparam int maxLines    = 200;

    logic                 Clock;
    logic                 arstN;
    // Bit 0 regOut up to bit 25 outPortIn, same order as the DUT ports
    logic [25:0]          ctrl;
    aluOpE                aluOp;
    logic [dataWidth-1:0] inPort;
    logic [dataWidth-1:0] busData;
    logic [dataWidth-1:0] outPort;
    logic                 busConflict;
    int                   errorCount = 0;
    int                   checkCount = 0;
    int                   fileHandle;

    busDatapath u_dut (
        .Clock(Clock), .arstN(arstN),
        .regOut(ctrl[0]), .hiOut(ctrl[1]), .loOut(ctrl[2]), .zHighOut(ctrl[3]),
        .zLowOut(ctrl[4]), .pcOut(ctrl[5]), .mdrOut(ctrl[6]), .inPortOut(ctrl[7]),
        .cOut(ctrl[8]), .pcIn(ctrl[9]), .incPc(ctrl[10]), .irIn(ctrl[11]),
        .marIn(ctrl[12]), .mdrIn(ctrl[13]), .read(ctrl[14]), .write(ctrl[15]),
        .yIn(ctrl[16]), .zIn(ctrl[17]), .hiIn(ctrl[18]), .loIn(ctrl[19]),
        .regIn(ctrl[20]), .gra(ctrl[21]), .grb(ctrl[22]), .grc(ctrl[23]),
        .baOut(ctrl[24]), .outPortIn(ctrl[25]),
        .aluOp(aluOp), .inPort(inPort),
        .busData(busData), .outPort(outPort), .busConflict(busConflict)
    );

    initial begin
        Clock = 1'b0;
        forever #(clockPeriod / 2) Clock = ~Clock;
    end

    task automatic driveStep(input logic [31:0] ctrlWord, input logic [31:0] opWord,
                             input logic [31:0] inWord);
        ctrl   = ctrlWord[25:0];
        aluOp  = aluOpE'(opWord[4:0]);
        inPort = inWord;
    endtask

    task automatic compareValue(input string what, input logic [31:0] actual,
                                input logic [31:0] expected, input int lineNo);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("MISMATCH at time %0t: line %0d, %s is %h, expected %h",
                     $time, lineNo, what, actual, expected);
        end
    endtask

    initial begin
        string       lineText;
        logic [31:0] ctrlWord;
        logic [31:0] opWord;
        logic [31:0] inWord;
        logic [31:0] expWord;
        int          flag;
        int          fields;
        int          lineNo;

        ctrl   = '0;
        aluOp  = opAdd;
        inPort = '0;
        arstN  = 1'b0;
        lineNo = 0;
        repeat (resetCycles) @(posedge Clock);
        #driveDelay;
        arstN = 1'b1;

        fileHandle = $fopen("dv/busDatapath_input.txt", "r");
        if (fileHandle == 0) begin
            errorCount++;
            $display("Could not open the stimulus file dv/busDatapath_input.txt");
        end else begin
            // One control step per clock, bounded by the line limit
            while (lineNo < maxLines && $fgets(lineText, fileHandle) != 0) begin
                lineNo++;
                if (lineText.len() < 2 || lineText[0] == "#") begin
                    continue;
                end
                fields = $sscanf(lineText, "%h %h %h %h %d",
                                 ctrlWord, opWord, inWord, expWord, flag);
                if (fields != 5) begin
                    errorCount++;
                    $display("Line %0d of the stimulus file could not be parsed", lineNo);
                    continue;
                end
                @(posedge Clock);
                #driveDelay;
                driveStep(ctrlWord, opWord, inWord);
                #sampleDelay;
                if (flag == 1) begin
                    compareValue("busData", busData, expWord, lineNo);
                end else if (flag == 2) begin
                    compareValue("outPort", outPort, expWord, lineNo);
                end
                // Each step enables at most one bus source
                compareValue("busConflict", {31'b0, busConflict}, 32'h0, lineNo);
            end
            if (lineNo >= maxLines && !$feof(fileHandle)) begin
                errorCount++;
                $display("Stimulus file is longer than %0d lines, reading stopped", maxLines);
            end
            $fclose(fileHandle);
        end

        if (checkCount == 0) begin
            errorCount++;
            $display("No checks were run, the stimulus file held no usable steps");
        end

        // Idle step so the last loads settle under the bound assertions
        @(posedge Clock);
        #driveDelay;
        driveStep('0, 32'h3, '0);
        @(posedge Clock);

        errorCount = errorCount + u_dut.uChk.failCount;
        $display("Checks run: %0d, bound assertion failures: %0d, errors: %0d",
                 checkCount, u_dut.uChk.failCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== dv/busDatapath_chk.sv ====
`timescale 1ns/1ps
module busDatapathChk (
    input logic                            Clock,
    input logic                            arstN,
    input logic                            busConflict,
    input logic                            irIn,
    input logic [busCpuPkg::dataWidth-1:0] busData,
    input logic [busCpuPkg::dataWidth-1:0] pcValue,
    input logic [busCpuPkg::dataWidth-1:0] irValue,
    input logic [busCpuPkg::dataWidth-1:0] regValue,
    input logic [busCpuPkg::dataWidth-1:0] hiValue,
    input logic [busCpuPkg::dataWidth-1:0] loValue,
    input logic [busCpuPkg::dataWidth-1:0] zHigh,
    input logic [busCpuPkg::dataWidth-1:0] zLow,
    input logic [busCpuPkg::dataWidth-1:0] mdrValue,
    input logic [busCpuPkg::dataWidth-1:0] outPort
);

    int failCount = 0;

    // One bus owner per cycle
    singleOwner: assert property (@(posedge Clock) disable iff (!arstN) !busConflict)
        else begin
            $error("Bus conflict, more than one source enabled at once");
            failCount = failCount + 1;
        end

    // Everything visible starts cleared in the first cycle out of reset
    resetCleared: assert property (@(posedge Clock) $rose(arstN) |->
        (pcValue == '0 && irValue == '0 && regValue == '0 && hiValue == '0 &&
         loValue == '0 && zHigh == '0 && zLow == '0 && mdrValue == '0 && outPort == '0))
        else begin
            $error("A register is not zero in the first cycle after reset");
            failCount = failCount + 1;
        end

    irCapture: assert property (@(posedge Clock) disable iff (!arstN)
        irIn |=> (irValue == $past(busData)))
        else begin
            $error("IR does not hold the bus value of the irIn cycle");
            failCount = failCount + 1;
        end

endmodule

bind busDatapath busDatapathChk uChk (
    .Clock(Clock), .arstN(arstN), .busConflict(busConflict), .irIn(irIn),
    .busData(busData), .pcValue(pcValue), .irValue(irValue), .regValue(regValue),
    .hiValue(hiValue), .loValue(loValue), .zHigh(zHigh), .zLow(zLow),
    .mdrValue(mdrValue), .outPort(outPort)
);

// ==== dv/busDatapath_input.txt ====
# control(hex, bit0 regOut .. bit25 outPortIn) aluOp(hex) inPort(hex) expected(hex) flag
# flag 0 no check, 1 compare busData, 2 compare outPort
00001020 03 00000000 00000000 1
00000002 03 00000000 00000000 1
00002080 03 1A87FFF0 1A87FFF0 1
0000A080 03 00000000 00000000 1
00001020 03 00000000 00000000 1
00004000 03 00000000 00000000 0
00000840 03 00000000 1A87FFF0 1
00000500 03 00000000 FFFFFFF0 1
00000020 03 00000000 00000001 1
00040080 03 CAFE0001 CAFE0001 1
00300002 03 00000000 CAFE0001 1
00200001 03 00000000 CAFE0001 1
00080080 03 12345678 12345678 1
00900004 03 00000000 12345678 1
00800001 03 00000000 12345678 1
00010080 03 800000F1 800000F1 1
00020080 03 00000010 00000010 1
00000010 03 00000000 80000101 1
00020080 04 000000F2 000000F2 1
00000010 03 00000000 7FFFFFFF 1
00020080 05 FFFF00F0 FFFF00F0 1
00000010 03 00000000 800000F0 1
00020080 06 0F000000 0F000000 1
00000010 03 00000000 8F0000F1 1
00020080 09 FFFFFFE4 FFFFFFE4 1
00000010 03 00000000 0800000F 1
00020080 0B 00000008 00000008 1
00000010 03 00000000 0000F100 1
00020080 07 00000004 00000004 1
00000010 03 00000000 1800000F 1
00020080 08 00000004 00000004 1
00000010 03 00000000 00000F18 1
00020080 11 00000005 00000005 1
00000010 03 00000000 FFFFFFFB 1
00020080 12 0F0F0F0F 0F0F0F0F 1
00000010 03 00000000 F0F0F0F0 1
00010080 03 FFFFFFFE FFFFFFFE 1
00020080 0F 40000003 40000003 1
00000008 03 00000000 FFFFFFFF 1
00000010 03 00000000 7FFFFFFA 1
00010080 03 FFFFFFF9 FFFFFFF9 1
00020080 10 00000002 00000002 1
00000008 03 00000000 FFFFFFFF 1
00000010 03 00000000 FFFFFFFD 1
00020000 10 00000000 00000000 1
00000008 03 00000000 FFFFFFF9 1
00000010 03 00000000 FFFFFFFF 1
00500080 03 DEADBEEF DEADBEEF 1
00400001 03 00000000 DEADBEEF 1
01400001 03 00000000 00000000 1
02000080 03 A5A55A5A A5A55A5A 1
00000000 03 00000000 A5A55A5A 2

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps
module aluUnit (
    input  logic                            Clock,
    input  logic                            arstN,
    input  logic [busCpuPkg::dataWidth-1:0] busData,
    input  busCpuPkg::aluOpE                aluOp,
    input  logic                            yIn,
    input  logic                            zIn,
    input  logic                            hiIn,
    input  logic                            loIn,
    output logic [busCpuPkg::dataWidth-1:0] zHigh,
    output logic [busCpuPkg::dataWidth-1:0] zLow,
    output logic [busCpuPkg::dataWidth-1:0] hiValue,
    output logic [busCpuPkg::dataWidth-1:0] loValue
);
    import busCpuPkg::*;

    logic [dataWidth-1:0]          yReg;
    logic [2*dataWidth-1:0]        zReg;
    logic [dataWidth-1:0]          hiReg;
    logic [dataWidth-1:0]          loReg;
    logic [2*dataWidth-1:0]        aluResult;
    logic [2*dataWidth-1:0]        rorWord;
    logic [2*dataWidth-1:0]        rolWord;
    logic signed [2*dataWidth-1:0] product;
    logic signed [dataWidth-1:0]   quotient;
    logic signed [dataWidth-1:0]   remainder;
    logic [4:0]                    shamt;

    assign shamt = busData[4:0];

    // Rotates shift a doubled copy of Y and keep one half
    assign rorWord = {yReg, yReg} >> shamt;
    assign rolWord = {yReg, yReg} << shamt;

    assign product = $signed(yReg) * $signed(busData);

    always_comb begin
        if (busData == '0) begin
            quotient  = '1;
            remainder = $signed(yReg);
        end else begin
            quotient  = $signed(yReg) / $signed(busData);
            remainder = $signed(yReg) % $signed(busData);
        end
    end

    // Upper half stays zero for single-word results
    always_comb begin
        aluResult = '0;
        case (aluOp)
            opAdd:   aluResult[dataWidth-1:0] = yReg + busData;
            opSub:   aluResult[dataWidth-1:0] = yReg - busData;
            opAnd:   aluResult[dataWidth-1:0] = yReg & busData;
            opOr:    aluResult[dataWidth-1:0] = yReg | busData;
            opShr:   aluResult[dataWidth-1:0] = yReg >> shamt;
            opShl:   aluResult[dataWidth-1:0] = yReg << shamt;
            opRor:   aluResult[dataWidth-1:0] = rorWord[dataWidth-1:0];
            opRol:   aluResult[dataWidth-1:0] = rolWord[2*dataWidth-1:dataWidth];
            opMul:   aluResult = product;
            opDiv:   aluResult = {remainder, quotient};
            opNeg:   aluResult[dataWidth-1:0] = -busData;
            opNot:   aluResult[dataWidth-1:0] = ~busData;
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            yReg  <= '0;
            zReg  <= '0;
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (yIn) yReg <= busData;
            if (zIn) zReg <= aluResult;
            if (hiIn) hiReg <= busData;
            if (loIn) loReg <= busData;
        end
    end

    assign zHigh   = zReg[2*dataWidth-1:dataWidth];
    assign zLow    = zReg[dataWidth-1:0];
    assign hiValue = hiReg;
    assign loValue = loReg;

endmodule

// ==== source/busArbiter.sv ====
`timescale 1ns/1ps
module busArbiter (
    input  logic                           regOut,
    input  logic                           hiOut,
    input  logic                           loOut,
    input  logic                           zHighOut,
    input  logic                           zLowOut,
    input  logic                           pcOut,
    input  logic                           mdrOut,
    input  logic                           inPortOut,
    input  logic                           cOut,
    input  logic [busCpuPkg::dataWidth-1:0] regData,
    input  logic [busCpuPkg::dataWidth-1:0] hiData,
    input  logic [busCpuPkg::dataWidth-1:0] loData,
    input  logic [busCpuPkg::dataWidth-1:0] zHighData,
    input  logic [busCpuPkg::dataWidth-1:0] zLowData,
    input  logic [busCpuPkg::dataWidth-1:0] pcData,
    input  logic [busCpuPkg::dataWidth-1:0] mdrData,
    input  logic [busCpuPkg::dataWidth-1:0] inPortData,
    input  logic [busCpuPkg::dataWidth-1:0] immData,
    output logic [busCpuPkg::dataWidth-1:0] busData,
    output busCpuPkg::busSourceE           busSource,
    output logic                           busConflict
);
    import busCpuPkg::*;

    logic [8:0] requests;

    assign requests = {cOut, inPortOut, mdrOut, pcOut, zLowOut,
                       zHighOut, loOut, hiOut, regOut};

    // Lowest request bit wins, matching the enum order
    always_comb begin
        busSource = srcNone;
        for (int i = 8; i >= 0; i--) begin
            if (requests[i]) begin
                busSource = busSourceE'(i + 1);
            end
        end
    end

    always_comb begin
        case (busSource)
            srcReg:    busData = regData;
            srcHi:     busData = hiData;
            srcLo:     busData = loData;
            srcZHigh:  busData = zHighData;
            srcZLow:   busData = zLowData;
            srcPc:     busData = pcData;
            srcMdr:    busData = mdrData;
            srcInPort: busData = inPortData;
            srcImm:    busData = immData;
            default:   busData = '0;
        endcase
    end

    // More than one driver asked for the bus
    assign busConflict = ($countones(requests) > 1);

endmodule

// ==== source/busCpuPkg.sv ====
package busCpuPkg;

    // Datapath and register file sizes
    localparam int dataWidth   = 32;
    localparam int regCount    = 16;
    localparam int regIdxWidth = 4;

    // Word-addressed RAM behind MAR and MDR
    localparam int memDepth     = 512;
    localparam int memAddrWidth = 9;

    // Instruction field positions
    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 27;
    localparam int raMsb     = 26;
    localparam int raLsb     = 23;
    localparam int rbMsb     = 22;
    localparam int rbLsb     = 19;
    localparam int rcMsb     = 18;
    localparam int rcLsb     = 15;
    localparam int immMsb    = 18;
    localparam int immLsb    = 0;

    // ALU operation, same encoding as the opcode field of the instruction
    typedef enum logic [4:0] {
        opAdd = 5'd3,
        opSub = 5'd4,
        opAnd = 5'd5,
        opOr  = 5'd6,
        opRor = 5'd7,
        opRol = 5'd8,
        opShr = 5'd9,
        opShl = 5'd11,
        opMul = 5'd15,
        opDiv = 5'd16,
        opNeg = 5'd17,
        opNot = 5'd18
    } aluOpE;

    // Bus owner, listed in arbitration priority order after srcNone
    // Ten sources need four bits
    typedef enum logic [3:0] {
        srcNone, srcReg, srcHi, srcLo, srcZHigh,
        srcZLow, srcPc, srcMdr, srcInPort, srcImm
    } busSourceE;

endpackage

// ==== source/busDatapath.sv ====
`timescale 1ns/1ps
module busDatapath (
    input  logic                            Clock,
    input  logic                            arstN,
    // Bus drive strobes
    input  logic                            regOut,
    input  logic                            hiOut,
    input  logic                            loOut,
    input  logic                            zHighOut,
    input  logic                            zLowOut,
    input  logic                            pcOut,
    input  logic                            mdrOut,
    input  logic                            inPortOut,
    input  logic                            cOut,
    // Load strobes
    input  logic                            pcIn,
    input  logic                            incPc,
    input  logic                            irIn,
    input  logic                            marIn,
    input  logic                            mdrIn,
    input  logic                            read,
    input  logic                            write,
    input  logic                            yIn,
    input  logic                            zIn,
    input  logic                            hiIn,
    input  logic                            loIn,
    input  logic                            regIn,
    input  logic                            gra,
    input  logic                            grb,
    input  logic                            grc,
    input  logic                            baOut,
    input  logic                            outPortIn,
    input  busCpuPkg::aluOpE                aluOp,
    input  logic [busCpuPkg::dataWidth-1:0] inPort,
    output logic [busCpuPkg::dataWidth-1:0] busData,
    output logic [busCpuPkg::dataWidth-1:0] outPort,
    output logic                            busConflict
);
    import busCpuPkg::*;

    logic [dataWidth-1:0] pcValue;
    logic [dataWidth-1:0] irValue;
    logic [dataWidth-1:0] immValue;
    logic [dataWidth-1:0] regValue;
    logic [dataWidth-1:0] zHigh;
    logic [dataWidth-1:0] zLow;
    logic [dataWidth-1:0] hiValue;
    logic [dataWidth-1:0] loValue;
    logic [dataWidth-1:0] mdrValue;

    busArbiter uArbiter (
        .regOut(regOut), .hiOut(hiOut), .loOut(loOut),
        .zHighOut(zHighOut), .zLowOut(zLowOut), .pcOut(pcOut),
        .mdrOut(mdrOut), .inPortOut(inPortOut), .cOut(cOut),
        .regData(regValue), .hiData(hiValue), .loData(loValue),
        .zHighData(zHigh), .zLowData(zLow), .pcData(pcValue),
        .mdrData(mdrValue), .inPortData(inPort), .immData(immValue),
        .busData(busData), .busSource(), .busConflict(busConflict)
    );

    fetchRegisters uFetch (
        .Clock(Clock), .arstN(arstN), .busData(busData),
        .pcIn(pcIn), .incPc(incPc), .irIn(irIn),
        .pcValue(pcValue), .irValue(irValue), .immValue(immValue)
    );

    registerFile uRegFile (
        .Clock(Clock), .arstN(arstN), .busData(busData), .irValue(irValue),
        .gra(gra), .grb(grb), .grc(grc), .regIn(regIn), .baOut(baOut),
        .regValue(regValue)
    );

    aluUnit uAlu (
        .Clock(Clock), .arstN(arstN), .busData(busData), .aluOp(aluOp),
        .yIn(yIn), .zIn(zIn), .hiIn(hiIn), .loIn(loIn),
        .zHigh(zHigh), .zLow(zLow), .hiValue(hiValue), .loValue(loValue)
    );

    memoryInterface uMemory (
        .Clock(Clock), .arstN(arstN), .busData(busData),
        .marIn(marIn), .mdrIn(mdrIn), .read(read), .write(write),
        .mdrValue(mdrValue)
    );

    // Output port register
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            outPort <= '0;
        end else if (outPortIn) begin
            outPort <= busData;
        end
    end

endmodule

// ==== source/fetchRegisters.sv ====
`timescale 1ns/1ps
module fetchRegisters (
    input  logic                            Clock,
    input  logic                            arstN,
    input  logic [busCpuPkg::dataWidth-1:0] busData,
    input  logic                            pcIn,
    input  logic                            incPc,
    input  logic                            irIn,
    output logic [busCpuPkg::dataWidth-1:0] pcValue,
    output logic [busCpuPkg::dataWidth-1:0] irValue,
    output logic [busCpuPkg::dataWidth-1:0] immValue
);
    import busCpuPkg::*;

    localparam int immWidth = immMsb - immLsb + 1;

    logic [dataWidth-1:0] pcReg;
    logic [dataWidth-1:0] irReg;

    // A bus load takes precedence over the increment
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pcReg <= '0;
        end else if (pcIn) begin
            pcReg <= busData;
        end else if (incPc) begin
            pcReg <= pcReg + 1'b1;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            irReg <= '0;
        end else if (irIn) begin
            irReg <= busData;
        end
    end

    assign pcValue = pcReg;
    assign irValue = irReg;

    // Immediate field, sign-extended to the bus width
    assign immValue = {{(dataWidth - immWidth){irReg[immMsb]}}, irReg[immMsb:immLsb]};

endmodule

// ==== source/memoryInterface.sv ====
`timescale 1ns/1ps
module memoryInterface (
    input  logic                            Clock,
    input  logic                            arstN,
    input  logic [busCpuPkg::dataWidth-1:0] busData,
    input  logic                            marIn,
    input  logic                            mdrIn,
    input  logic                            read,
    input  logic                            write,
    output logic [busCpuPkg::dataWidth-1:0] mdrValue
);
    import busCpuPkg::*;

    logic [memAddrWidth-1:0] marReg;
    logic [dataWidth-1:0]    mdrReg;
    logic [dataWidth-1:0]    ram [memDepth];
    logic [dataWidth-1:0]    ramData;

    // Only the low address bits reach the RAM
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            marReg <= '0;
        end else if (marIn) begin
            marReg <= busData[memAddrWidth-1:0];
        end
    end

    // Synchronous RAM port, read and write share MAR
    always_ff @(posedge Clock) begin
        if (write) begin
            ram[marReg] <= mdrReg;
        end
    end

    assign ramData = ram[marReg];

    // Memory read wins over a bus load
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            mdrReg <= '0;
        end else if (read) begin
            mdrReg <= ramData;
        end else if (mdrIn) begin
            mdrReg <= busData;
        end
    end

    assign mdrValue = mdrReg;

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
module registerFile (
    input  logic                            Clock,
    input  logic                            arstN,
    input  logic [busCpuPkg::dataWidth-1:0] busData,
    input  logic [busCpuPkg::dataWidth-1:0] irValue,
    input  logic                            gra,
    input  logic                            grb,
    input  logic                            grc,
    input  logic                            regIn,
    input  logic                            baOut,
    output logic [busCpuPkg::dataWidth-1:0] regValue
);
    import busCpuPkg::*;

    logic [dataWidth-1:0]   regs [regCount];
    logic [regIdxWidth-1:0] regIdx;

    // Field select, gra first when several are raised
    always_comb begin
        if (gra) begin
            regIdx = irValue[raMsb:raLsb];
        end else if (grb) begin
            regIdx = irValue[rbMsb:rbLsb];
        end else if (grc) begin
            regIdx = irValue[rcMsb:rcLsb];
        end else begin
            regIdx = '0;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regIn) begin
            regs[regIdx] <= busData;
        end
    end

    // Base address read of R0 gives zero, R0 still holds its value
    always_comb begin
        if (baOut && (regIdx == '0)) begin
            regValue = '0;
        end else begin
            regValue = regs[regIdx];
        end
    end

endmodule
